/* logic/banner_pkg.sv */
package banner_pkg;

	// ########################################
	// Screen geometry
	// ########################################

	localparam int COORD_W = 11;
	typedef logic [COORD_W-1:0] coord_t;

	localparam int SLOT_COUNT = 6;
	typedef logic [2:0] slot_t;

	localparam int GLYPH_W = 50;
	localparam int GLYPH_H = 41;
	typedef logic [5:0] bit_idx_t;  // 0..GLYPH_W-1, counted from the right edge
	typedef logic [5:0] row_idx_t;  // 0..GLYPH_H-1, counted from the band top

	localparam coord_t BAND_TOP = 11'd280;

	// A slot covers the columns from its edge minus 49 up to the edge itself
	localparam coord_t [0:SLOT_COUNT-1] SLOT_RIGHT_EDGE = '{
		11'd250, 11'd310, 11'd370, 11'd480, 11'd540, 11'd600
	};

	// ########################################
	// Glyph memory
	// ########################################

	localparam int GLYPH_DEPTH = SLOT_COUNT * GLYPH_H;  // One entry per slot-row
	localparam int GLYPH_ADDR_W = $clog2(GLYPH_DEPTH);
	typedef logic [GLYPH_W-1:0] glyph_row_t;
	typedef logic [GLYPH_ADDR_W-1:0] glyph_addr_t;
	localparam string GLYPH_FILE = "glyphs.mem";

	// ########################################
	// Colour and rotation
	// ########################################

	typedef logic [2:0] color_t;
	localparam color_t COLOR_BG = 3'd7;

	typedef logic [2:0] phase_t;
	localparam phase_t PHASE_LAST = phase_t'(SLOT_COUNT - 1);

	typedef logic [31:0] tick_t;
	localparam int unsigned ROTATE_PERIOD_DEFAULT = 1562501;

endpackage

/* logic/slot_decoder.sv */
`timescale 1ns/1ps

module slot_decoder (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 pixel_valid,
	input  banner_pkg::coord_t   col,
	input  banner_pkg::coord_t   row,
	output logic                 s1_valid,
	output logic                 s1_hit,
	output banner_pkg::slot_t    s1_slot,
	output banner_pkg::row_idx_t s1_row_idx,
	output banner_pkg::bit_idx_t s1_bit_idx
);
	import banner_pkg::*;

	logic                  in_band;
	logic [SLOT_COUNT-1:0] in_slot;
	logic                  col_hit;
	logic                  hit;
	slot_t                 slot_sel;
	coord_t                edge_sel;
	coord_t                row_off;
	coord_t                bit_off;

	// ########################################
	// Window decode
	// ########################################

	assign in_band = (row >= BAND_TOP) && (row < BAND_TOP + coord_t'(GLYPH_H));
	assign row_off = row - BAND_TOP;

	for (genvar i = 0; i < SLOT_COUNT; i++) begin : g_window
		assign in_slot[i] = (col > SLOT_RIGHT_EDGE[i] - coord_t'(GLYPH_W)) &&
			(col <= SLOT_RIGHT_EDGE[i]);
	end

	// The windows never overlap, so at most one bit of in_slot is set
	always_comb begin
		slot_sel = '0;
		edge_sel = '0;
		for (int i = 0; i < SLOT_COUNT; i++) begin
			if (in_slot[i]) begin
				slot_sel = slot_t'(i);
				edge_sel = SLOT_RIGHT_EDGE[i];
			end
		end
	end

	assign col_hit = |in_slot;
	assign hit = in_band && col_hit;
	assign bit_off = edge_sel - col;  // Bit 49 is the leftmost column of a glyph

	// ########################################
	// Stage 1 register
	// ########################################

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			s1_valid <= 1'b0;
		end else begin
			s1_valid <= pixel_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (pixel_valid) begin
			s1_hit <= hit;
			s1_slot <= slot_sel;
			s1_row_idx <= hit ? row_idx_t'(row_off) : '0;  // Keeps the address in range
			s1_bit_idx <= hit ? bit_idx_t'(bit_off) : '0;
		end
	end

endmodule

/* logic/glyph_shader.sv */
`timescale 1ns/1ps

module glyph_shader (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 s1_valid,
	input  logic                 s1_hit,
	input  banner_pkg::slot_t    s1_slot,
	input  banner_pkg::row_idx_t s1_row_idx,
	input  banner_pkg::bit_idx_t s1_bit_idx,
	input  banner_pkg::phase_t   phase,
	output logic                 color_valid,
	output banner_pkg::color_t   color
);
	import banner_pkg::*;

	glyph_row_t  glyph_mem [GLYPH_DEPTH];
	glyph_addr_t glyph_addr;
	glyph_row_t  glyph_row;
	logic        glyph_bit;
	logic [3:0]  slot_ext;
	logic [3:0]  phase_ext;
	logic [3:0]  rot_diff;
	color_t      ink_color;
	color_t      pixel_color;

	// ########################################
	// Glyph lookup
	// ########################################

	initial begin
		$readmemb(GLYPH_FILE, glyph_mem);  // Six letters of 41 rows each, in slot order
	end

	assign glyph_addr = glyph_addr_t'(s1_slot) * glyph_addr_t'(GLYPH_H) +
		glyph_addr_t'(s1_row_idx);
	assign glyph_row = glyph_mem[glyph_addr];
	assign glyph_bit = glyph_row[s1_bit_idx];

	// ########################################
	// Colour rotation
	// ########################################

	// Colour is ((slot - phase) mod 6) + 1, so slot 0 at phase 2 gets colour 5
	assign slot_ext = {1'b0, s1_slot};
	assign phase_ext = {1'b0, phase};
	assign rot_diff = (slot_ext >= phase_ext) ? slot_ext - phase_ext :
		slot_ext + 4'(SLOT_COUNT) - phase_ext;
	assign ink_color = color_t'(rot_diff) + color_t'(1);

	assign pixel_color = (s1_hit && glyph_bit) ? ink_color : COLOR_BG;

	// ########################################
	// Stage 2 register
	// ########################################

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			color_valid <= 1'b0;
		end else begin
			color_valid <= s1_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (s1_valid) begin
			color <= pixel_color;
		end
	end

endmodule

/* logic/color_rotator.sv */
`timescale 1ns/1ps

module color_rotator #(
	parameter int unsigned rotate_period = banner_pkg::ROTATE_PERIOD_DEFAULT
) (
	input  logic               clk,
	input  logic               arst_n,
	output banner_pkg::phase_t phase
);
	import banner_pkg::*;

	tick_t tick;
	logic  tick_wrap;

	assign tick_wrap = (tick == tick_t'(rotate_period - 1));  // Last clock of a period

	// ########################################
	// Tick counter
	// ########################################

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			tick <= '0;
		end else if (tick_wrap) begin
			tick <= '0;
		end else begin
			tick <= tick + tick_t'(1);
		end
	end

	// ########################################
	// Phase counter
	// ########################################

	// Steps once per period and wraps from 5 back to 0
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			phase <= '0;
		end else if (tick_wrap) begin
			phase <= (phase == PHASE_LAST) ? '0 : phase + phase_t'(1);
		end
	end

endmodule

/* logic/banner_top.sv */
`timescale 1ns/1ps

module banner_top #(
	parameter int unsigned rotate_period = banner_pkg::ROTATE_PERIOD_DEFAULT
) (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               pixel_valid,
	input  banner_pkg::coord_t col,
	input  banner_pkg::coord_t row,
	output logic               color_valid,
	output banner_pkg::color_t color
);
	import banner_pkg::*;

	logic     s1_valid;
	logic     s1_hit;
	slot_t    s1_slot;
	row_idx_t s1_row_idx;
	bit_idx_t s1_bit_idx;
	phase_t   phase;

	// ########################################
	// Pixel pipeline
	// ########################################

	slot_decoder u_slot_decoder (
		.clk         (clk),
		.arst_n      (arst_n),
		.pixel_valid (pixel_valid),
		.col         (col),
		.row         (row),
		.s1_valid    (s1_valid),
		.s1_hit      (s1_hit),
		.s1_slot     (s1_slot),
		.s1_row_idx  (s1_row_idx),
		.s1_bit_idx  (s1_bit_idx)
	);

	glyph_shader u_glyph_shader (
		.clk         (clk),
		.arst_n      (arst_n),
		.s1_valid    (s1_valid),
		.s1_hit      (s1_hit),
		.s1_slot     (s1_slot),
		.s1_row_idx  (s1_row_idx),
		.s1_bit_idx  (s1_bit_idx),
		.phase       (phase),       // Sampled one cycle after acceptance
		.color_valid (color_valid),
		.color       (color)
	);

	// ########################################
	// Colour rotation
	// ########################################

	color_rotator #(
		.rotate_period (rotate_period)
	) u_color_rotator (
		.clk    (clk),
		.arst_n (arst_n),
		.phase  (phase)
	);

endmodule

/* testbench/banner_assertions.sv */
`timescale 1ns/1ps

module banner_assertions (
	input logic               clk,
	input logic               arst_n,
	input logic               s1_valid,
	input logic               s1_hit,
	input logic               color_valid,
	input banner_pkg::color_t color
);
	import banner_pkg::*;

	// ########################################
	// Stage 2 timing
	// ########################################

	valid_follows: assert property (@(posedge clk) disable iff (!arst_n)
		s1_valid |=> color_valid)
		else $error("color_valid did not follow s1_valid");

	idle_follows: assert property (@(posedge clk) disable iff (!arst_n)
		!s1_valid |=> !color_valid)
		else $error("color_valid rose without s1_valid");

	// ########################################
	// Colour values
	// ########################################

	miss_is_bg: assert property (@(posedge clk) disable iff (!arst_n)
		(s1_valid && !s1_hit) |=> (color == COLOR_BG))
		else $error("a pixel outside every letter window was not background");

	never_zero: assert property (@(posedge clk) disable iff (!arst_n)
		color_valid |-> (color != color_t'(0)))
		else $error("colour code 0 came out with color_valid");

endmodule

bind glyph_shader banner_assertions u_banner_assertions (
	.clk         (clk),
	.arst_n      (arst_n),
	.s1_valid    (s1_valid),
	.s1_hit      (s1_hit),
	.color_valid (color_valid),
	.color       (color)
);

/* testbench/banner_tb.sv */
`timescale 1ns/1ps

module banner_tb;
	import banner_pkg::*;

	localparam int TB_PERIOD = 16;  // Short rotation period so phase changes are visible
	localparam int CLK_HALF = 4;
	localparam int RESET_CYCLES = 10;
	localparam int BURST_LEN = 200;
	localparam int ROTATE_SAMPLES = 7 * TB_PERIOD + 8;
	localparam int SCAN_PIXELS = SLOT_COUNT * GLYPH_W * GLYPH_H;
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + 40 + SCAN_PIXELS + ROTATE_SAMPLES +
		4 * BURST_LEN + 500;  // Gaps can triple the second burst
	localparam int unsigned SEED = 32'hc55a_3fc1;

	logic   clk;
	logic   arst_n;
	logic   pixel_valid;
	coord_t col;
	coord_t row;
	logic   color_valid;
	color_t color;

	logic [GLYPH_W-1:0] ref_glyph [SLOT_COUNT*GLYPH_H];
	int unsigned        cycle;
	int                 error_count = 0;
	int                 check_count = 0;
	int                 test_count = 0;
	int                 tests_failed = 0;
	coord_t             stim_col [$];
	coord_t             stim_row [$];
	logic               stim_valid [$];

	banner_top #(
		.rotate_period (TB_PERIOD)
	) u_banner_top (
		.clk         (clk),
		.arst_n      (arst_n),
		.pixel_valid (pixel_valid),
		.col         (col),
		.row         (row),
		.color_valid (color_valid),
		.color       (color)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#(CLK_HALF) clk = ~clk;
		end
	end

	// Counts clocks since reset release to predict the rotation phase
	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cycle <= 0;
		end else begin
			cycle <= cycle + 1;
		end
	end

	initial begin
		#(WATCHDOG_CYCLES * 2 * CLK_HALF);
		$display("timeout: the tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
		$display("TESTBENCH FAILED");
		$finish;
	end

	// ########################################
	// Reference model
	// ########################################

	function automatic int phase_at(input int unsigned n);
		return int'((n / TB_PERIOD) % SLOT_COUNT);
	endfunction

	function automatic color_t expected_color(input int c, input int r, input int ph);
		int                 s;
		int                 edge_col;
		logic [5:0]         bit_pos;
		logic [7:0]         addr;
		logic [GLYPH_W-1:0] glyph_row;
		color_t             result;
		result = COLOR_BG;
		if (r >= int'(BAND_TOP) && r < int'(BAND_TOP) + GLYPH_H) begin
			for (s = 0; s < SLOT_COUNT; s++) begin
				edge_col = int'(SLOT_RIGHT_EDGE[s]);
				if (c <= edge_col && c > edge_col - GLYPH_W) begin
					bit_pos = 6'(edge_col - c);  // Leftmost column is bit 49
					addr = 8'(s * GLYPH_H + r - int'(BAND_TOP));
					glyph_row = ref_glyph[addr];
					if (glyph_row[bit_pos]) begin
						result = color_t'((s - ph + SLOT_COUNT) % SLOT_COUNT + 1);
					end
				end
			end
		end
		return result;
	endfunction

	// ########################################
	// Stimulus and checking
	// ########################################

	task automatic queue_pixel(input coord_t c, input coord_t r);
		stim_col.push_back(c);
		stim_row.push_back(r);
		stim_valid.push_back(1'b1);
	endtask

	task automatic queue_idle();
		stim_col.push_back('0);
		stim_row.push_back('0);
		stim_valid.push_back(1'b0);
	endtask

	task automatic report_error(input string msg);
		$display("error at %0t ns: %s", $time, msg);
		error_count++;
	endtask

	// Drives one queued entry per falling edge and checks each result 2 cycles on
	task automatic run_stream();
		int unsigned exp_due [$];
		color_t      exp_color [$];
		int          exp_col [$];
		int          exp_row [$];
		while (stim_valid.size() > 0 || exp_due.size() > 0) begin
			@(negedge clk);
			if (exp_due.size() > 0 && exp_due[0] == cycle) begin
				check_count++;
				assert (color_valid === 1'b1) else begin
					$display("no result came out 2 cycles after acceptance, at %0t ns",
						$time);
					error_count++;
				end
				assert (color === exp_color[0]) else begin
					report_error($sformatf("pixel (%0d, %0d) gave colour %0d, expected %0d",
						exp_col[0], exp_row[0], color, exp_color[0]));
				end
				void'(exp_due.pop_front());
				void'(exp_color.pop_front());
				void'(exp_col.pop_front());
				void'(exp_row.pop_front());
			end else begin
				assert (color_valid === 1'b0) else begin
					$display("color_valid was high with no pixel accepted %s, at %0t ns",
						"2 cycles before", $time);
					error_count++;
				end
			end
			if (stim_valid.size() > 0) begin
				pixel_valid = stim_valid.pop_front();
				col = stim_col.pop_front();
				row = stim_row.pop_front();
				if (pixel_valid) begin
					exp_due.push_back(cycle + 2);
					exp_color.push_back(expected_color(int'(col), int'(row),
						phase_at(cycle + 1)));
					exp_col.push_back(int'(col));
					exp_row.push_back(int'(row));
				end
			end else begin
				pixel_valid = 1'b0;
			end
		end
	endtask

	task automatic close_test(input string name, input int start_errors);
		test_count++;
		if (error_count == start_errors) begin
			$display("test %-12s ok", name);
		end else begin
			tests_failed++;
			$display("test %-12s %0d errors", name, error_count - start_errors);
		end
	endtask

	// ########################################
	// Directed tests
	// ########################################

	task automatic reset_sequence();
		int start;
		start = error_count;
		arst_n = 1'b0;
		repeat (RESET_CYCLES) begin
			@(negedge clk);
			check_count++;
			assert (color_valid === 1'b0) else begin
				$display("color_valid was not low during reset, at %0t ns", $time);
				error_count++;
			end
		end
		arst_n = 1'b1;
		repeat (6) queue_idle();  // Nothing accepted yet, so no result may appear
		run_stream();
		close_test("reset", start);
	endtask

	task automatic background_pixels();
		int start;
		int i;
		int bg_col [10] = '{220, 230, 230, 255, 200, 311, 400, 601, 0, 2047};
		int bg_row [10] = '{100, 279, 321, 300, 300, 300, 300, 300, 0, 2047};
		start = error_count;
		for (i = 0; i < 10; i++) begin
			assert (expected_color(bg_col[i], bg_row[i], 0) == COLOR_BG) else begin
				$display("background pixel (%0d, %0d) lies on a letter", bg_col[i], bg_row[i]);
				error_count++;
			end
			queue_pixel(coord_t'(bg_col[i]), coord_t'(bg_row[i]));
		end
		run_stream();
		close_test("background", start);
	endtask

	task automatic glyph_ink_scan();
		int start;
		int s;
		int r;
		int b;
		start = error_count;
		for (s = 0; s < SLOT_COUNT; s++) begin
			for (r = 0; r < GLYPH_H; r++) begin
				for (b = 0; b < GLYPH_W; b++) begin
					queue_pixel(coord_t'(int'(SLOT_RIGHT_EDGE[s]) - GLYPH_W + 1 + b),
						coord_t'(int'(BAND_TOP) + r));
				end
			end
		end
		run_stream();
		close_test("glyph_ink", start);
	endtask

	task automatic colour_rotation();
		int start;
		int rot_col;
		int rot_row;
		start = error_count;
		rot_col = int'(SLOT_RIGHT_EDGE[0]) - GLYPH_W + 9;  // Left stem of the first letter
		rot_row = int'(BAND_TOP) + 10;
		assert (expected_color(rot_col, rot_row, 0) != COLOR_BG) else begin
			$display("the rotation pixel (%0d, %0d) is not inked", rot_col, rot_row);
			error_count++;
		end
		repeat (ROTATE_SAMPLES) queue_pixel(coord_t'(rot_col), coord_t'(rot_row));
		run_stream();
		close_test("rotation", start);
	endtask

	task automatic stream_throughput();
		int start;
		int first_col;
		int last_col;
		int last_row;
		start = error_count;
		first_col = int'(SLOT_RIGHT_EDGE[0]) - GLYPH_W + 1;
		last_col = int'(SLOT_RIGHT_EDGE[SLOT_COUNT-1]);
		last_row = int'(BAND_TOP) + GLYPH_H - 1;
		repeat (BURST_LEN) begin
			queue_pixel(coord_t'($urandom_range(last_col, first_col)),
				coord_t'($urandom_range(last_row, int'(BAND_TOP))));
		end
		run_stream();
		repeat (BURST_LEN) begin
			repeat ($urandom_range(2)) queue_idle();
			queue_pixel(coord_t'($urandom_range(last_col, first_col)),
				coord_t'($urandom_range(last_row, int'(BAND_TOP))));
		end
		run_stream();
		close_test("throughput", start);
	endtask

	initial begin
		void'($urandom(SEED));
		arst_n = 1'b0;
		pixel_valid = 1'b0;
		col = '0;
		row = '0;
		$readmemb(GLYPH_FILE, ref_glyph);
		reset_sequence();
		background_pixels();
		glyph_ink_scan();
		colour_rotation();
		stream_throughput();
		$display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
			test_count, tests_failed, check_count, error_count);
		if (error_count == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

/* logic/glyphs.mem */
// One 50-bit glyph row per line, the leftmost character is the leftmost pixel of the letter
// 41 rows per letter, letters in slot order H U E L I T
00000000000000000000000000000000000000000000000000
00000000000000000000000000000000000000000000000000
00000111111110000000000000000000000001111111100000
00000111111110000000000000000000000001111111100000
00000111111110000000000000000000000001111111100000
00000111111110000000000000000000000001111111100000
00000111111110000000000000000000000001111111100000
00000111111110000000000000000000000001111111100000
00000111111110000000000000000000000001111111100000
00000111111110000000000000000000000001111111100000
00000111111110000000000000000000000001111111100000
00000111111110000000000000000000000001111111100000
00000111111110000000000000000000000001111111100000
00000111111110000000000000000000000001111111100000
00000111111110000000000000000000000001111111100000
00000111111110000000000000000000000001111111100000
00000111111110000000000000000000000001111111100000
00000111111110000000000000000000000001111111100000
00000111111111111111111111111111111111111111100000
00000111111111111111111111111111111111111111100000
00000111111111111111111111111111111111111111100000
00000111111111111111111111111111111111111111100000
00000111111111111111111111111111111111111111100000
00000111111111111111111111111111111111111111100000
00000111111110000000000000000000000001111111100000
00000111111110000000000000000000000001111111100000
00000111111110000000000000000000000001111111100000
00000111111110000000000000000000000001111111100000
00000111111110000000000000000000000001111111100000
00000111111110000000000000000000000001111111100000
00000111111110000000000000000000000001111111100000
00000111111110000000000000000000000001111111100000
00000111111110000000000000000000000001111111100000
00000111111110000000000000000000000001111111100000
00000111111110000000000000000000000001111111100000
00000111111110000000000000000000000001111111100000
00000111111110000000000000000000000001111111100000
00000111111110000000000000000000000001111111100000
00000111111110000000000000000000000001111111100000
00000000000000000000000000000000000000000000000000
00000000000000000000000000000000000000000000000000
00000000000000000000000000000000000000000000000000
00000000000000000000000000000000000000000000000000
00000111111110000000000000000000000001111111100000
00000111111110000000000000000000000001111111100000
00000111111110000000000000000000000001111111100000
00000111111110000000000000000000000001111111100000
00000111111110000000000000000000000001111111100000
00000111111110000000000000000000000001111111100000
00000111111110000000000000000000000001111111100000
00000111111110000000000000000000000001111111100000
00000111111110000000000000000000000001111111100000
00000111111110000000000000000000000001111111100000
00000111111110000000000000000000000001111111100000
00000111111110000000000000000000000001111111100000
00000111111110000000000000000000000001111111100000
00000111111110000000000000000000000001111111100000
00000111111110000000000000000000000001111111100000
00000111111110000000000000000000000001111111100000
00000111111110000000000000000000000001111111100000
00000111111110000000000000000000000001111111100000
00000111111110000000000000000000000001111111100000
00000111111110000000000000000000000001111111100000
00000111111110000000000000000000000001111111100000
00000111111110000000000000000000000001111111100000
00000111111110000000000000000000000001111111100000
00000111111110000000000000000000000001111111100000
00000111111110000000000000000000000001111111100000
00000111111110000000000000000000000001111111100000
00000111111110000000000000000000000001111111100000
00000111111110000000000000000000000001111111100000
00000111111110000000000000000000000001111111100000
00000111111110000000000000000000000001111111100000
00000111111111111111111111111111111111111111100000
00000111111111111111111111111111111111111111100000
00000111111111111111111111111111111111111111100000
00000111111111111111111111111111111111111111100000
00000111111111111111111111111111111111111111100000
00000111111111111111111111111111111111111111100000
00000000000000000000000000000000000000000000000000
00000000000000000000000000000000000000000000000000
00000000000000000000000000000000000000000000000000
00000000000000000000000000000000000000000000000000
00000111111111111111111111111111111111111111100000
00000111111111111111111111111111111111111111100000
00000111111111111111111111111111111111111111100000
00000111111111111111111111111111111111111111100000
00000111111111111111111111111111111111111111100000
00000111111111111111111111111111111111111111100000
00000111111110000000000000000000000000000000000000
00000111111110000000000000000000000000000000000000
00000111111110000000000000000000000000000000000000
00000111111110000000000000000000000000000000000000
00000111111110000000000000000000000000000000000000
00000111111110000000000000000000000000000000000000
00000111111110000000000000000000000000000000000000
00000111111110000000000000000000000000000000000000
00000111111110000000000000000000000000000000000000
00000111111110000000000000000000000000000000000000
00000111111111111111111111111111111111110000000000
00000111111111111111111111111111111111110000000000
00000111111111111111111111111111111111110000000000
00000111111111111111111111111111111111110000000000
00000111111111111111111111111111111111110000000000
00000111111111111111111111111111111111110000000000
00000111111110000000000000000000000000000000000000
00000111111110000000000000000000000000000000000000
00000111111110000000000000000000000000000000000000
00000111111110000000000000000000000000000000000000
00000111111110000000000000000000000000000000000000
00000111111110000000000000000000000000000000000000
00000111111110000000000000000000000000000000000000
00000111111110000000000000000000000000000000000000
00000111111110000000000000000000000000000000000000
00000111111111111111111111111111111111111111100000
00000111111111111111111111111111111111111111100000
00000111111111111111111111111111111111111111100000
00000111111111111111111111111111111111111111100000
00000111111111111111111111111111111111111111100000
00000111111111111111111111111111111111111111100000
00000000000000000000000000000000000000000000000000
00000000000000000000000000000000000000000000000000
00000000000000000000000000000000000000000000000000
00000000000000000000000000000000000000000000000000
00000111111110000000000000000000000000000000000000
00000111111110000000000000000000000000000000000000
00000111111110000000000000000000000000000000000000
00000111111110000000000000000000000000000000000000
00000111111110000000000000000000000000000000000000
00000111111110000000000000000000000000000000000000
00000111111110000000000000000000000000000000000000
00000111111110000000000000000000000000000000000000
00000111111110000000000000000000000000000000000000
00000111111110000000000000000000000000000000000000
00000111111110000000000000000000000000000000000000
00000111111110000000000000000000000000000000000000
00000111111110000000000000000000000000000000000000
00000111111110000000000000000000000000000000000000
00000111111110000000000000000000000000000000000000
00000111111110000000000000000000000000000000000000
00000111111110000000000000000000000000000000000000
00000111111110000000000000000000000000000000000000
00000111111110000000000000000000000000000000000000
00000111111110000000000000000000000000000000000000
00000111111110000000000000000000000000000000000000
00000111111110000000000000000000000000000000000000
00000111111110000000000000000000000000000000000000
00000111111110000000000000000000000000000000000000
00000111111110000000000000000000000000000000000000
00000111111110000000000000000000000000000000000000
00000111111110000000000000000000000000000000000000
00000111111110000000000000000000000000000000000000
00000111111110000000000000000000000000000000000000
00000111111110000000000000000000000000000000000000
00000111111110000000000000000000000000000000000000
00000111111111111111111111111111111111111111100000
00000111111111111111111111111111111111111111100000
00000111111111111111111111111111111111111111100000
00000111111111111111111111111111111111111111100000
00000111111111111111111111111111111111111111100000
00000111111111111111111111111111111111111111100000
00000000000000000000000000000000000000000000000000
00000000000000000000000000000000000000000000000000
00000000000000000000000000000000000000000000000000
00000000000000000000000000000000000000000000000000
00000111111111111111111111111111111111111111100000
00000111111111111111111111111111111111111111100000
00000111111111111111111111111111111111111111100000
00000111111111111111111111111111111111111111100000
00000111111111111111111111111111111111111111100000
00000111111111111111111111111111111111111111100000
00000000000000000000011111111000000000000000000000
00000000000000000000011111111000000000000000000000
00000000000000000000011111111000000000000000000000
00000000000000000000011111111000000000000000000000
00000000000000000000011111111000000000000000000000
00000000000000000000011111111000000000000000000000
00000000000000000000011111111000000000000000000000
00000000000000000000011111111000000000000000000000
00000000000000000000011111111000000000000000000000
00000000000000000000011111111000000000000000000000
00000000000000000000011111111000000000000000000000
00000000000000000000011111111000000000000000000000
00000000000000000000011111111000000000000000000000
00000000000000000000011111111000000000000000000000
00000000000000000000011111111000000000000000000000
00000000000000000000011111111000000000000000000000
00000000000000000000011111111000000000000000000000
00000000000000000000011111111000000000000000000000
00000000000000000000011111111000000000000000000000
00000000000000000000011111111000000000000000000000
00000000000000000000011111111000000000000000000000
00000000000000000000011111111000000000000000000000
00000000000000000000011111111000000000000000000000
00000000000000000000011111111000000000000000000000
00000000000000000000011111111000000000000000000000
00000111111111111111111111111111111111111111100000
00000111111111111111111111111111111111111111100000
00000111111111111111111111111111111111111111100000
00000111111111111111111111111111111111111111100000
00000111111111111111111111111111111111111111100000
00000111111111111111111111111111111111111111100000
00000000000000000000000000000000000000000000000000
00000000000000000000000000000000000000000000000000
00000000000000000000000000000000000000000000000000
00000000000000000000000000000000000000000000000000
00000111111111111111111111111111111111111111100000
00000111111111111111111111111111111111111111100000
00000111111111111111111111111111111111111111100000
00000111111111111111111111111111111111111111100000
00000111111111111111111111111111111111111111100000
00000111111111111111111111111111111111111111100000
00000000000000000000011111111000000000000000000000
00000000000000000000011111111000000000000000000000
00000000000000000000011111111000000000000000000000
00000000000000000000011111111000000000000000000000
00000000000000000000011111111000000000000000000000
00000000000000000000011111111000000000000000000000
00000000000000000000011111111000000000000000000000
00000000000000000000011111111000000000000000000000
00000000000000000000011111111000000000000000000000
00000000000000000000011111111000000000000000000000
00000000000000000000011111111000000000000000000000
00000000000000000000011111111000000000000000000000
00000000000000000000011111111000000000000000000000
00000000000000000000011111111000000000000000000000
00000000000000000000011111111000000000000000000000
00000000000000000000011111111000000000000000000000
00000000000000000000011111111000000000000000000000
00000000000000000000011111111000000000000000000000
00000000000000000000011111111000000000000000000000
00000000000000000000011111111000000000000000000000
00000000000000000000011111111000000000000000000000
00000000000000000000011111111000000000000000000000
00000000000000000000011111111000000000000000000000
00000000000000000000011111111000000000000000000000
00000000000000000000011111111000000000000000000000
00000000000000000000011111111000000000000000000000
00000000000000000000011111111000000000000000000000
00000000000000000000011111111000000000000000000000
00000000000000000000011111111000000000000000000000
00000000000000000000011111111000000000000000000000
00000000000000000000011111111000000000000000000000
00000000000000000000000000000000000000000000000000
00000000000000000000000000000000000000000000000000

/* sim.f */
logic/banner_pkg.sv
logic/slot_decoder.sv
logic/glyph_shader.sv
logic/color_rotator.sv
logic/banner_top.sv
testbench/banner_assertions.sv
testbench/banner_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP      = banner_tb
FILELIST = sim.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: sim clean

# The glyph file is read by name, so the model runs from the logic folder
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	cd logic && ../$(BUILD)/V$(TOP) > ../$(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG) && ! grep -q "TESTBENCH FAILED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
